// ==== rtl/bpu_macros.svh ====
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// table index is pc[9:2]
`define BPU_INDEX_W 8

// btb tag is pc[31:10]
`define BPU_TAG_W 22

`define BPU_RAS_DEPTH 8

`endif

// ==== rtl/bpu_inst_pkg.sv ====
`default_nettype none

package bpu_inst_pkg;

    typedef enum logic [1:0] {
        BK_NONE     = 2'b00,
        BK_COND     = 2'b01,
        BK_DIRECT   = 2'b10,
        BK_INDIRECT = 2'b11
    } branch_kind_t;

    // call/return marking for the return stack
    typedef enum logic [1:0] {
        LK_NONE   = 2'b00,
        LK_CALL   = 2'b01,
        LK_RETURN = 2'b10
    } link_kind_t;

    // major opcode, inst[31:26]
    localparam logic [5:0] OP_B    = 6'b010100;
    localparam logic [5:0] OP_BL   = 6'b010101;
    localparam logic [5:0] OP_JIRL = 6'b010011;

    localparam logic [5:0] OP_COND_FIRST = 6'b010110; // beq
    localparam logic [5:0] OP_COND_LAST  = 6'b011011; // bgeu

endpackage

`default_nettype wire

// ==== rtl/bpu_train_pkg.sv ====
`default_nettype none

`include "bpu_macros.svh"

package bpu_train_pkg;

    // 2 and 3 predict taken
    typedef logic [1:0] counter_t;

    localparam counter_t CNT_RESET = 2'd1; // weakly not taken

    typedef struct packed {
        logic                  valid;
        logic [`BPU_TAG_W-1:0] tag;
        logic [31:0]           target;
    } btb_entry_t;

    // resolved branch from execute
    typedef struct packed {
        logic                       enable;
        logic [31:0]                pc;
        logic [31:0]                target;
        logic                       taken;
        bpu_inst_pkg::branch_kind_t kind;
    } update_t;

endpackage

`default_nettype wire

// ==== rtl/bpu_lookup_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bpu_lookup_if;

    logic [1:0][31:0] lookup_pc;  // per slot fetch pc
    logic [1:0]       pht_taken;
    logic [1:0]       btb_hit;    // valid and tag match
    logic [1:0][31:0] btb_target;

    modport pht_mp (
        input  lookup_pc,
        output pht_taken
    );

    modport btb_mp (
        input  lookup_pc,
        output btb_hit,
        output btb_target
    );

    modport sel_mp (
        output lookup_pc,
        input  pht_taken,
        input  btb_hit,
        input  btb_target
    );

endinterface

`default_nettype wire

// ==== rtl/predecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module predecoder (
    input  logic [31:0]                inst_i,
    input  logic [31:0]                pc_i,
    output bpu_inst_pkg::branch_kind_t kind_o,
    output bpu_inst_pkg::link_kind_t   link_o,
    output logic [31:0]                target_o
);

    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [25:0] offs26;
    logic [15:0] offs16;
    logic [31:0] direct_tgt;
    logic [31:0] cond_tgt;

    assign opcode = inst_i[31:26];
    assign rd     = inst_i[4:0];
    assign rj     = inst_i[9:5];

    // b/bl split the offset, high part sits in the low bits
    assign offs26 = {inst_i[9:0], inst_i[25:10]};
    assign offs16 = inst_i[25:10];

    assign direct_tgt = pc_i + {{4{offs26[25]}}, offs26, 2'b00};
    assign cond_tgt   = pc_i + {{14{offs16[15]}}, offs16, 2'b00};

    always_comb begin
        kind_o   = bpu_inst_pkg::BK_NONE;
        link_o   = bpu_inst_pkg::LK_NONE;
        target_o = '0;
        if (opcode == bpu_inst_pkg::OP_B || opcode == bpu_inst_pkg::OP_BL) begin
            kind_o   = bpu_inst_pkg::BK_DIRECT;
            target_o = direct_tgt;
            if (opcode == bpu_inst_pkg::OP_BL) begin
                link_o = bpu_inst_pkg::LK_CALL;
            end
        end else if (opcode >= bpu_inst_pkg::OP_COND_FIRST &&
                     opcode <= bpu_inst_pkg::OP_COND_LAST) begin
            kind_o   = bpu_inst_pkg::BK_COND;
            target_o = cond_tgt;
        end else if (opcode == bpu_inst_pkg::OP_JIRL) begin
            kind_o = bpu_inst_pkg::BK_INDIRECT; // target comes from ras or btb
            if (rd == 5'd0 && rj == 5'd1) begin
                link_o = bpu_inst_pkg::LK_RETURN; // jirl r0, ra
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pred_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bpu_macros.svh"

module pred_table #(
    parameter type    entry_t     = logic,
    parameter entry_t RESET_VALUE = entry_t'(0)
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic [1:0][`BPU_INDEX_W-1:0] rd_idx_i,
    output entry_t [1:0]                 rd_data_o,
    input  logic [`BPU_INDEX_W-1:0]      upd_idx_i,
    output entry_t                       upd_data_o,
    input  logic                         wr_en_i,
    input  entry_t                       wr_data_i
);

    localparam int DEPTH = 1 << `BPU_INDEX_W;

    entry_t mem_q [DEPTH];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= RESET_VALUE;
            end
        end else if (wr_en_i) begin
            mem_q[upd_idx_i] <= wr_data_i;
        end
    end

    // lookups see the old value on a same-cycle write
    assign rd_data_o[0] = mem_q[rd_idx_i[0]];
    assign rd_data_o[1] = mem_q[rd_idx_i[1]];

    assign upd_data_o = mem_q[upd_idx_i]; // for read-modify-write

endmodule

`default_nettype wire

// ==== rtl/pht_d.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bpu_macros.svh"

module pht_d (
    input logic                   clk,
    input logic                   arst_n_i,
    bpu_lookup_if.pht_mp          lk,
    input bpu_train_pkg::update_t upd_i
);

    logic [1:0][`BPU_INDEX_W-1:0]      rd_idx;
    bpu_train_pkg::counter_t [1:0]     rd_cnt;
    bpu_train_pkg::counter_t           upd_cnt;
    bpu_train_pkg::counter_t           nxt_cnt;
    logic                              wr_en;

    assign rd_idx[0] = lk.lookup_pc[0][`BPU_INDEX_W+1:2];
    assign rd_idx[1] = lk.lookup_pc[1][`BPU_INDEX_W+1:2];

    assign lk.pht_taken[0] = rd_cnt[0][1];
    assign lk.pht_taken[1] = rd_cnt[1][1];

    assign wr_en = upd_i.enable && (upd_i.kind == bpu_inst_pkg::BK_COND);

    // saturate at 0 and 3
    always_comb begin
        nxt_cnt = upd_cnt;
        if (upd_i.taken) begin
            if (upd_cnt != 2'd3) begin
                nxt_cnt = upd_cnt + 2'd1;
            end
        end else if (upd_cnt != 2'd0) begin
            nxt_cnt = upd_cnt - 2'd1;
        end
    end

    pred_table #(
        .entry_t     (bpu_train_pkg::counter_t),
        .RESET_VALUE (bpu_train_pkg::CNT_RESET)
    ) u_table (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rd_idx_i   (rd_idx),
        .rd_data_o  (rd_cnt),
        .upd_idx_i  (upd_i.pc[`BPU_INDEX_W+1:2]),
        .upd_data_o (upd_cnt),
        .wr_en_i    (wr_en),
        .wr_data_i  (nxt_cnt)
    );

endmodule

`default_nettype wire

// ==== rtl/btb_d.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bpu_macros.svh"

module btb_d (
    input logic                   clk,
    input logic                   arst_n_i,
    bpu_lookup_if.btb_mp          lk,
    input bpu_train_pkg::update_t upd_i
);

    localparam int TAG_LSB = 32 - `BPU_TAG_W;

    logic [1:0][`BPU_INDEX_W-1:0]       rd_idx;
    bpu_train_pkg::btb_entry_t [1:0]    rd_ent;
    bpu_train_pkg::btb_entry_t          upd_ent;
    bpu_train_pkg::btb_entry_t          new_ent;
    logic                               wr_en;

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign rd_idx[i] = lk.lookup_pc[i][`BPU_INDEX_W+1:2];
        assign lk.btb_hit[i] = rd_ent[i].valid &&
                               (rd_ent[i].tag == lk.lookup_pc[i][31:TAG_LSB]);
        assign lk.btb_target[i] = rd_ent[i].target;
    end

    assign new_ent.valid  = 1'b1;
    assign new_ent.tag    = upd_i.pc[31:TAG_LSB];
    assign new_ent.target = upd_i.target;

    // skip the write when the entry already holds it
    assign wr_en = upd_i.enable &&
                   (upd_i.kind == bpu_inst_pkg::BK_INDIRECT) &&
                   (upd_ent != new_ent);

    pred_table #(
        .entry_t     (bpu_train_pkg::btb_entry_t),
        .RESET_VALUE (bpu_train_pkg::btb_entry_t'(0)) // all invalid
    ) u_table (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rd_idx_i   (rd_idx),
        .rd_data_o  (rd_ent),
        .upd_idx_i  (upd_i.pc[`BPU_INDEX_W+1:2]),
        .upd_data_o (upd_ent),
        .wr_en_i    (wr_en),
        .wr_data_i  (new_ent)
    );

endmodule

`default_nettype wire

// ==== rtl/ras_d.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bpu_macros.svh"

module ras_d (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        push_i,
    input  logic [31:0] push_addr_i,
    input  logic        pop_i,
    output logic [31:0] top_o,
    output logic        empty_o
);

    localparam int PTR_W = $clog2(`BPU_RAS_DEPTH);
    localparam int CNT_W = $clog2(`BPU_RAS_DEPTH + 1);

    logic [31:0]      stack_q [`BPU_RAS_DEPTH];
    logic [PTR_W-1:0] top_q;    // slot of the newest entry
    logic [PTR_W-1:0] top_inc;
    logic [CNT_W-1:0] count_q;
    logic             full;

    assign top_inc = top_q + PTR_W'(1); // wraps, so a full push drops the oldest
    assign full    = (count_q == CNT_W'(`BPU_RAS_DEPTH));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            top_q   <= '0;
            count_q <= '0;
        end else if (push_i) begin
            top_q <= top_inc;
            if (!full) begin
                count_q <= count_q + CNT_W'(1);
            end
        end else if (pop_i && !empty_o) begin
            top_q   <= top_q - PTR_W'(1);
            count_q <= count_q - CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_q[top_inc] <= push_addr_i;
        end
    end

    assign top_o   = stack_q[top_q];
    assign empty_o = (count_q == '0);

endmodule

`default_nettype wire

// ==== rtl/bpu_d.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_d (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             stall_i,
    input  logic [1:0][31:0] pc_i,
    input  logic [1:0][31:0] inst_i,
    input  logic [1:0]       valid_i,
    input  logic             upd_en_i,
    input  logic [31:0]      upd_pc_i,
    input  logic [31:0]      upd_target_i,
    input  logic             upd_taken_i,
    input  logic [1:0]       upd_kind_i,
    output logic             redirect_o,
    output logic [31:0]      redirect_pc_o,
    output logic [1:0]       taken_slot_o,
    output logic [1:0]       fetch_keep_o,
    output logic [1:0][1:0]  branch_kind_o
);

    bpu_lookup_if lk_if ();

    bpu_train_pkg::update_t               upd;
    logic                                 redirect_q;
    logic [1:0]                           slot_ok;
    logic [1:0][31:0]                     dec_inst;
    bpu_inst_pkg::branch_kind_t [1:0]     kind;
    bpu_inst_pkg::link_kind_t [1:0]       link;
    logic [1:0][31:0]                     pd_target;
    logic [1:0]                           take;
    logic [1:0][31:0]                     take_pc;
    logic [31:0]                          ras_top;
    logic                                 ras_empty;
    logic                                 win;
    logic                                 ras_push;
    logic                                 ras_pop;

    // shadow kill for the slots fetched behind a redirect
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= redirect_o;
        end
    end

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign slot_ok[i]  = valid_i[i] && !stall_i && !redirect_q;
        assign dec_inst[i] = slot_ok[i] ? inst_i[i] : '0; // zero decodes as no branch

        predecoder u_predecoder (
            .inst_i   (dec_inst[i]),
            .pc_i     (pc_i[i]),
            .kind_o   (kind[i]),
            .link_o   (link[i]),
            .target_o (pd_target[i])
        );

        assign branch_kind_o[i] = kind[i];
    end

    assign lk_if.lookup_pc = pc_i;

    assign upd.enable = upd_en_i;
    assign upd.pc     = upd_pc_i;
    assign upd.target = upd_target_i;
    assign upd.taken  = upd_taken_i;
    assign upd.kind   = bpu_inst_pkg::branch_kind_t'(upd_kind_i);

    pht_d u_pht_d (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .lk       (lk_if.pht_mp),
        .upd_i    (upd)
    );

    btb_d u_btb_d (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .lk       (lk_if.btb_mp),
        .upd_i    (upd)
    );

    // per slot taken decision and its target
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            take[i]    = 1'b0;
            take_pc[i] = pd_target[i];
            case (kind[i])
                bpu_inst_pkg::BK_DIRECT: take[i] = 1'b1;
                bpu_inst_pkg::BK_COND:   take[i] = lk_if.pht_taken[i];
                bpu_inst_pkg::BK_INDIRECT: begin
                    if (link[i] == bpu_inst_pkg::LK_RETURN) begin
                        take[i]    = !ras_empty;
                        take_pc[i] = ras_top;
                    end else begin
                        take[i]    = lk_if.btb_hit[i];
                        take_pc[i] = lk_if.btb_target[i];
                    end
                end
                default: take[i] = 1'b0;
            endcase
        end
    end

    // slot 0 first, program order
    always_comb begin
        redirect_o    = 1'b0;
        redirect_pc_o = '0;
        taken_slot_o  = 2'b00;
        fetch_keep_o  = 2'b11;
        win           = 1'b0;
        if (take[0]) begin
            redirect_o    = 1'b1;
            redirect_pc_o = take_pc[0];
            taken_slot_o  = 2'b01;
            fetch_keep_o  = 2'b01; // drop slot 1
        end else if (take[1]) begin
            redirect_o    = 1'b1;
            redirect_pc_o = take_pc[1];
            taken_slot_o  = 2'b10;
            win           = 1'b1;
        end
    end

    // only the redirecting slot touches the stack
    assign ras_push = redirect_o && (link[win] == bpu_inst_pkg::LK_CALL);
    assign ras_pop  = redirect_o && (link[win] == bpu_inst_pkg::LK_RETURN);

    ras_d u_ras_d (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .push_i      (ras_push),
        .push_addr_i (pc_i[win] + 32'd4),
        .pop_i       (ras_pop),
        .top_o       (ras_top),
        .empty_o     (ras_empty)
    );

endmodule

`default_nettype wire

// ==== verif/bpu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_assert (
    input logic       clk,
    input logic       arst_n_i,
    input logic       stall_i,
    input logic       redirect_o,
    input logic [1:0] taken_slot_o,
    input logic [1:0] fetch_keep_o
);

    int fail_cnt = 0; // read by the testbench at the end

    onehot_slot: assert property (@(posedge clk) disable iff (!arst_n_i)
        redirect_o |-> $onehot(taken_slot_o))
        else begin
            $error("redirect without exactly one taken slot bit");
            fail_cnt++;
        end

    idle_slot: assert property (@(posedge clk) disable iff (!arst_n_i)
        !redirect_o |-> taken_slot_o == 2'b00)
        else begin
            $error("taken slot set without a redirect");
            fail_cnt++;
        end

    keep_first: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_keep_o[0])
        else begin
            $error("slot 0 dropped from the fetch bundle");
            fail_cnt++;
        end

    // shadow of a redirect never redirects
    shadow_kill: assert property (@(posedge clk) disable iff (!arst_n_i)
        redirect_o |=> !redirect_o)
        else begin
            $error("redirect in the cycle after a redirect");
            fail_cnt++;
        end

    stall_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i |-> !redirect_o)
        else begin
            $error("redirect while stalled");
            fail_cnt++;
        end

endmodule

bind bpu_d bpu_assert bpu_assert_inst (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .stall_i      (stall_i),
    .redirect_o   (redirect_o),
    .taken_slot_o (taken_slot_o),
    .fetch_keep_o (fetch_keep_o)
);

`default_nettype wire

// ==== verif/bpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bpu_macros.svh"

module bpu_tb;

    localparam logic [5:0] OP_B    = 6'b010100;
    localparam logic [5:0] OP_BL   = 6'b010101;
    localparam logic [5:0] OP_JIRL = 6'b010011;
    localparam logic [5:0] OP_BEQ  = 6'b010110;

    logic clk, arst_n_i, stall_i, upd_en_i, upd_taken_i;
    logic [1:0][31:0] pc_i, inst_i;
    logic [1:0] valid_i, upd_kind_i, taken_slot_o, fetch_keep_o;
    logic [31:0] upd_pc_i, upd_target_i, redirect_pc_o;
    logic redirect_o;
    logic [1:0][1:0] branch_kind_o;

    // reference model state
    logic [1:0] m_cnt [256];
    logic m_btb_valid [256];
    logic [21:0] m_btb_tag [256];
    logic [31:0] m_btb_tgt [256];
    logic [31:0] m_ras [$];
    logic m_prev_redir, e_redir, s_en, s_taken;
    logic [1:0] e_link, s_kind;
    logic [31:0] e_push_pc, s_pc, s_tgt;
    integer seed;
    int errors, test_base, n_tests, n_failed;

    bpu_d bpu_d_inst (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall_i),
        .pc_i(pc_i), .inst_i(inst_i), .valid_i(valid_i),
        .upd_en_i(upd_en_i), .upd_pc_i(upd_pc_i), .upd_target_i(upd_target_i),
        .upd_taken_i(upd_taken_i), .upd_kind_i(upd_kind_i),
        .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o),
        .taken_slot_o(taken_slot_o), .fetch_keep_o(fetch_keep_o),
        .branch_kind_o(branch_kind_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] enc_b(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]}; // high offset bits go low
    endfunction

    function automatic logic [31:0] enc_jirl(input logic [4:0] rj, input logic [4:0] rd);
        return {OP_JIRL, 16'h0, rj, rd};
    endfunction

    function automatic logic [31:0] random_inst(input logic [2:0] sel, input logic [31:0] body);
        case (sel)
            3'd0: return {OP_B, body[25:0]};
            3'd1: return {OP_BL, body[25:0]};
            3'd2: return {OP_JIRL, body[25:0]};
            3'd3: return {OP_JIRL, body[25:10], 10'b00001_00000}; // return
            3'd4: return {OP_BEQ, body[25:0]};
            3'd5: return {6'b011011, body[25:0]};
            default: return {6'b000000, body[25:0]};
        endcase
    endfunction

    function automatic void predecode(input logic [31:0] inst, input logic [31:0] pc,
                                      output logic [1:0] kind, output logic [1:0] link,
                                      output logic [31:0] tgt);
        logic [5:0] op;
        logic [25:0] o26;
        logic [15:0] o16;
        op = inst[31:26];
        o26 = {inst[9:0], inst[25:10]};
        o16 = inst[25:10];
        kind = 2'b00;
        link = 2'b00;
        tgt = 32'h0;
        if (op == OP_B || op == OP_BL) begin
            kind = 2'b10;
            link = (op == OP_BL) ? 2'b01 : 2'b00;
            tgt = pc + {{4{o26[25]}}, o26, 2'b00};
        end else if (op >= 6'b010110 && op <= 6'b011011) begin
            kind = 2'b01;
            tgt = pc + {{14{o16[15]}}, o16, 2'b00};
        end else if (op == OP_JIRL) begin
            kind = 2'b11;
            link = (inst[4:0] == 5'd0 && inst[9:5] == 5'd1) ? 2'b10 : 2'b00;
        end
    endfunction

    task automatic check_outputs();
        logic [1:0] kind [2];
        logic [1:0] link [2];
        logic [31:0] tgt [2];
        logic [31:0] tpc [2];
        logic [1:0] take;
        logic [7:0] idx;
        logic [31:0] exp_pc;
        logic [1:0] exp_slot;
        logic [1:0] exp_keep;
        for (int i = 0; i < 2; i++) begin
            kind[i] = 2'b00;
            link[i] = 2'b00;
            tgt[i] = 32'h0;
            if (valid_i[i] && !stall_i && !m_prev_redir) begin
                predecode(inst_i[i], pc_i[i], kind[i], link[i], tgt[i]);
            end
            idx = pc_i[i][9:2];
            take[i] = (kind[i] == 2'b10) || (kind[i] == 2'b01 && m_cnt[idx][1]);
            tpc[i] = tgt[i];
            if (kind[i] == 2'b11 && link[i] == 2'b10) begin
                take[i] = (m_ras.size() != 0);
                if (take[i]) tpc[i] = m_ras[$];
            end else if (kind[i] == 2'b11) begin
                take[i] = m_btb_valid[idx] && (m_btb_tag[idx] == pc_i[i][31:10]);
                tpc[i] = m_btb_tgt[idx];
            end
        end
        e_redir = take[0] || take[1];
        exp_pc = take[0] ? tpc[0] : (take[1] ? tpc[1] : 32'h0);
        exp_slot = take[0] ? 2'b01 : (take[1] ? 2'b10 : 2'b00);
        exp_keep = take[0] ? 2'b01 : 2'b11;
        e_link = take[0] ? link[0] : link[1];
        e_push_pc = (take[0] ? pc_i[0] : pc_i[1]) + 32'd4;
        assert ({redirect_o, redirect_pc_o, taken_slot_o, fetch_keep_o} ==
                {e_redir, exp_pc, exp_slot, exp_keep}) else begin
            $display("Mismatch at %0t: redirect %b pc %h slot %b keep %b, expected %b %h %b %b",
                     $time, redirect_o, redirect_pc_o, taken_slot_o, fetch_keep_o,
                     e_redir, exp_pc, exp_slot, exp_keep);
            errors++;
        end
        assert (branch_kind_o == {kind[1], kind[0]}) else begin
            $display("Mismatch at %0t: branch kinds %b, expected %b %b", $time,
                     branch_kind_o, kind[1], kind[0]);
            errors++;
        end
    endtask

    // state moves as the DUT will on the next edge
    task automatic advance_model();
        logic [7:0] idx;
        idx = upd_pc_i[9:2];
        if (upd_en_i && upd_kind_i == 2'b01) begin
            if (upd_taken_i && m_cnt[idx] != 2'd3) m_cnt[idx] = m_cnt[idx] + 2'd1;
            else if (!upd_taken_i && m_cnt[idx] != 2'd0) m_cnt[idx] = m_cnt[idx] - 2'd1;
        end
        if (upd_en_i && upd_kind_i == 2'b11) begin
            m_btb_valid[idx] = 1'b1;
            m_btb_tag[idx] = upd_pc_i[31:10];
            m_btb_tgt[idx] = upd_target_i;
        end
        if (e_redir && e_link == 2'b01) begin
            m_ras.push_back(e_push_pc);
            if (m_ras.size() > `BPU_RAS_DEPTH) void'(m_ras.pop_front()); // oldest lost
        end else if (e_redir && e_link == 2'b10) begin
            void'(m_ras.pop_back());
        end
        m_prev_redir = e_redir;
    endtask

    task automatic cycle(input logic [31:0] pc0, input logic [31:0] in0,
                         input logic [31:0] pc1, input logic [31:0] in1,
                         input logic [1:0] vld, input logic stl);
        @(posedge clk);
        pc_i[0] <= pc0;
        pc_i[1] <= pc1;
        inst_i[0] <= in0;
        inst_i[1] <= in1;
        valid_i <= vld;
        stall_i <= stl;
        upd_en_i <= s_en;
        upd_pc_i <= s_pc;
        upd_target_i <= s_tgt;
        upd_taken_i <= s_taken;
        upd_kind_i <= s_kind;
        @(negedge clk); // outputs settled
        check_outputs();
        advance_model();
        s_en = 1'b0;
    endtask

    task automatic idle();
        cycle(32'h0, 32'h0, 32'h4, 32'h0, 2'b00, 1'b0);
    endtask

    task automatic train(input logic [31:0] pc, input logic [31:0] tgt,
                         input logic taken, input logic [1:0] kind);
        s_en = 1'b1;
        s_pc = pc;
        s_tgt = tgt;
        s_taken = taken;
        s_kind = kind;
        idle();
    endtask

    function automatic int assert_failures();
        return bpu_d_inst.bpu_assert_inst.fail_cnt;
    endfunction

    task automatic end_test(input string name);
        int bad;
        bad = errors + assert_failures() - test_base;
        n_tests++;
        if (bad != 0) n_failed++;
        $display("test %0d %s: %s (%0d errors)", n_tests, name, bad == 0 ? "ok" : "bad", bad);
        test_base = errors + assert_failures();
    endtask

    initial begin
        for (int t = 0; t < 2000; t++) @(posedge clk);
        $display("timeout, the run did not finish within 2000 cycles");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        seed = 32'hb552_4b37;
        {stall_i, upd_en_i, upd_taken_i, valid_i, upd_kind_i} = '0;
        {pc_i, inst_i, upd_pc_i, upd_target_i} = '0;
        {s_en, s_taken, s_kind, s_pc, s_tgt} = '0;
        {errors, test_base, n_tests, n_failed} = '0;
        m_prev_redir = 1'b0;
        for (int i = 0; i < 256; i++) begin
            m_cnt[i] = 2'd1;
            m_btb_valid[i] = 1'b0;
            m_btb_tag[i] = '0;
            m_btb_tgt[i] = '0;
        end
        arst_n_i = 1'b0;
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;

        cycle(32'h1000, {OP_BEQ, 16'h0010, 10'h0}, 32'h1004, enc_jirl(5'd1, 5'd0), 2'b11, 1'b0);
        end_test("reset state");

        cycle(32'h2000, enc_b(OP_B, 26'h100), 32'h2004, 32'h0, 2'b11, 1'b0);
        cycle(32'h2400, enc_b(OP_B, 26'h40), 32'h2404, 32'h0, 2'b11, 1'b0); // shadow
        cycle(32'h3000, 32'h0, 32'h3004, enc_b(OP_B, 26'h3ff_fff0), 2'b11, 1'b0);
        cycle(32'h3400, 32'h0, 32'h3404, enc_b(OP_B, 26'h8), 2'b11, 1'b0);
        end_test("direct branches");

        train(32'h4000, 32'h0, 1'b1, 2'b01);
        train(32'h4000, 32'h0, 1'b1, 2'b01);
        cycle(32'h4000, {OP_BEQ, 16'hfff8, 10'h0}, 32'h4004, 32'h0, 2'b11, 1'b0);
        train(32'h4000, 32'h0, 1'b0, 2'b01);
        train(32'h4000, 32'h0, 1'b0, 2'b01);
        cycle(32'h4000, {OP_BEQ, 16'hfff8, 10'h0}, 32'h4004, 32'h0, 2'b11, 1'b0);
        end_test("conditional training");

        cycle(32'h5000, 32'h0, 32'h5004, enc_b(OP_BL, 26'h200), 2'b11, 1'b0);
        idle();
        cycle(32'h6000, enc_jirl(5'd1, 5'd0), 32'h6004, 32'h0, 2'b11, 1'b0);
        idle();
        cycle(32'h7000, enc_b(OP_BL, 26'h40), 32'h7004, 32'h0, 2'b11, 1'b0);
        idle();
        cycle(32'h7100, enc_b(OP_BL, 26'h40), 32'h7104, 32'h0, 2'b11, 1'b0);
        idle();
        cycle(32'h7200, enc_jirl(5'd1, 5'd0), 32'h7204, 32'h0, 2'b01, 1'b0);
        idle();
        cycle(32'h7300, enc_jirl(5'd1, 5'd0), 32'h7304, 32'h0, 2'b01, 1'b0);
        end_test("call and return");

        train(32'h8010, 32'h1234_5678, 1'b1, 2'b11);
        cycle(32'h8010, enc_jirl(5'd5, 5'd1), 32'h8014, 32'h0, 2'b11, 1'b0);
        idle();
        cycle(32'h8410, enc_jirl(5'd5, 5'd1), 32'h8414, 32'h0, 2'b11, 1'b0); // tag miss
        end_test("indirect target");

        cycle(32'h9000, enc_b(OP_BL, 26'h80), 32'h9004, 32'h0, 2'b01, 1'b0);
        idle();
        cycle(32'h9100, enc_b(OP_BL, 26'h80), 32'h9104, 32'h0, 2'b01, 1'b1);
        cycle(32'h9200, enc_jirl(5'd1, 5'd0), 32'h9204, 32'h0, 2'b01, 1'b0);
        end_test("stall");

        for (int n = 0; n < 80; n++) begin
            r0 = $random(seed);
            r1 = $random(seed);
            r2 = $random(seed);
            s_en = r2[14];
            s_pc = {20'h0, r2[11:2], 2'b00};
            s_tgt = {16'h0001, r2[31:18], 2'b00};
            s_taken = r2[15];
            s_kind = r2[13:12];
            cycle({20'h0, r0[11:2], 2'b00}, random_inst(r0[14:12], r1),
                  {20'h0, r0[11:2], 2'b00} + 32'd4, random_inst(r0[17:15], {r1[15:0], r1[31:16]}),
                  r0[29:28], r0[31:30] == 2'b11);
        end
        idle();
        end_test("random bundles");

        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 n_tests, n_failed, errors, assert_failures());
        if (errors + assert_failures() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
rtl/bpu_inst_pkg.sv
rtl/bpu_train_pkg.sv
rtl/bpu_lookup_if.sv
rtl/predecoder.sv
rtl/pred_table.sv
rtl/pht_d.sv
rtl/btb_d.sv
rtl/ras_d.sv
rtl/bpu_d.sv
verif/bpu_assert.sv
verif/bpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the bpu testbench with verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module bpu_tb -o bpu_sim || exit 1
out=$(./obj_dir/bpu_sim +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED" && exit 0 || exit 1
